// File: logic/fp16_pkg.sv
`default_nettype none

package fp16_pkg;

    // --------------------
    // binary16 format
    // --------------------

    // full word, exponent field, stored mantissa field
    localparam int FLOAT_W = 16;
    localparam int EXP_W = 5;
    localparam int MANT_W = 10;

    // --------------------
    // datapath widths
    // --------------------

    // hidden bit, mantissa, then guard, round and three sticky bits
    localparam int ALIGN_W = MANT_W + 6;

    // aligned width plus one carry bit out of the adder
    localparam int SUM_W = ALIGN_W + 1;

    // mantissa below the leading one, followed by guard, round and sticky
    localparam int NORM_W = MANT_W + 5;

    // --------------------
    // constants
    // --------------------

    // alignment shift saturates here
    localparam logic [EXP_W-1:0] MAX_SHIFT = 5'd15;

    // all-ones exponent marks inf and nan
    localparam logic [EXP_W-1:0] EXP_MAX = 5'd31;

    // canonical quiet nan: sign 0, exponent all ones, mantissa msb set
    localparam logic [FLOAT_W-1:0] QNAN = 16'h7E00;

    // one operand word, seen either raw or split into its fields
    typedef union packed {
        logic [FLOAT_W-1:0] raw;
        struct packed {
            logic              sign;
            logic [EXP_W-1:0]  exp;
            logic [MANT_W-1:0] mant;
        } fields;
    } fp16_t;

endpackage

`default_nettype wire

// File: logic/fp_align_stage.sv
`default_nettype none

module fp_align_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  fp16_pkg::fp16_t                a,
    input  fp16_pkg::fp16_t                b,
    output fp16_pkg::fp16_t                a_q,
    output fp16_pkg::fp16_t                b_q,
    output logic                           sign_a,
    output logic                           sign_b,
    output logic [fp16_pkg::EXP_W-1:0]     exp_a,
    output logic [fp16_pkg::EXP_W-1:0]     exp_b,
    output logic                           same_sign,
    output logic                           a_exp_ge,
    output logic                           a_mag_gt,
    output logic [fp16_pkg::ALIGN_W-1:0]   m_a,
    output logic [fp16_pkg::ALIGN_W-1:0]   m_b
);

    localparam int EXP_W = fp16_pkg::EXP_W;
    localparam int ALIGN_W = fp16_pkg::ALIGN_W;
    // zero bits appended below the stored mantissa
    localparam int EXT_W = ALIGN_W - fp16_pkg::MANT_W - 1;

    logic               a_ge_b;
    logic               b_ge_a;
    logic [EXP_W-1:0]   exp_diff;
    logic [EXP_W-1:0]   shift_amt;
    logic [ALIGN_W-1:0] pre_a;
    logic [ALIGN_W-1:0] pre_b;
    logic [ALIGN_W-1:0] sh_a;
    logic [ALIGN_W-1:0] sh_b;

    // --------------------
    // input register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else begin
            a_q <= a;
            b_q <= b;
        end
    end

    // --------------------
    // compare and align
    // --------------------

    // both flags set on equal exponents, so neither side shifts
    assign a_ge_b = (a_q.fields.exp >= b_q.fields.exp);
    assign b_ge_a = (b_q.fields.exp >= a_q.fields.exp);

    assign exp_diff = a_ge_b ? (a_q.fields.exp - b_q.fields.exp)
                             : (b_q.fields.exp - a_q.fields.exp);

    // a gap past the clamp leaves at most the hidden bit
    assign shift_amt = (exp_diff > fp16_pkg::MAX_SHIFT) ? fp16_pkg::MAX_SHIFT : exp_diff;

    // hidden bit only for a nonzero exponent
    // subnormals still align with their raw exponent of 0
    assign pre_a = {(a_q.fields.exp != '0), a_q.fields.mant, {EXT_W{1'b0}}};
    assign pre_b = {(b_q.fields.exp != '0), b_q.fields.mant, {EXT_W{1'b0}}};

    // only the smaller operand moves right
    assign sh_a = a_ge_b ? pre_a : (pre_a >> shift_amt);
    assign sh_b = b_ge_a ? pre_b : (pre_b >> shift_amt);

    // --------------------
    // align register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sign_a <= 1'b0;
            sign_b <= 1'b0;
            exp_a <= '0;
            exp_b <= '0;
            same_sign <= 1'b0;
            a_exp_ge <= 1'b0;
            a_mag_gt <= 1'b0;
            m_a <= '0;
            m_b <= '0;
        end else begin
            sign_a <= a_q.fields.sign;
            sign_b <= b_q.fields.sign;
            exp_a <= a_q.fields.exp;
            exp_b <= b_q.fields.exp;
            same_sign <= (a_q.fields.sign == b_q.fields.sign);
            a_exp_ge <= a_ge_b;
            // magnitude compare after alignment picks the subtrahend
            a_mag_gt <= (sh_a > sh_b);
            m_a <= sh_a;
            m_b <= sh_b;
        end
    end

    // a shift within the clamp never pushes the hidden bit out of the frame
    shift_clamped: assert property (@(posedge clk) disable iff (!rst_n)
        (!pre_a[ALIGN_W-1] || (sh_a != '0)) && (!pre_b[ALIGN_W-1] || (sh_b != '0)));

endmodule

`default_nettype wire

// File: logic/fp_special_path.sv
`default_nettype none

module fp_special_path #(
    parameter int SPECIAL_DELAY = 3
) (
    input  logic            clk,
    input  logic            rst_n,
    input  fp16_pkg::fp16_t a_q,
    input  fp16_pkg::fp16_t b_q,
    output logic            special_hit,
    output fp16_pkg::fp16_t special_result
);

    logic            nan_a;
    logic            nan_b;
    logic            inf_a;
    logic            inf_b;
    logic            hit_next;
    fp16_pkg::fp16_t res_next;

    // delay line, index 0 loads first
    logic            hit_pipe [SPECIAL_DELAY];
    fp16_pkg::fp16_t res_pipe [SPECIAL_DELAY];

    // --------------------
    // classify
    // --------------------
    assign nan_a = (a_q.fields.exp == fp16_pkg::EXP_MAX) && (a_q.fields.mant != '0);
    assign nan_b = (b_q.fields.exp == fp16_pkg::EXP_MAX) && (b_q.fields.mant != '0);
    assign inf_a = (a_q.fields.exp == fp16_pkg::EXP_MAX) && (a_q.fields.mant == '0);
    assign inf_b = (b_q.fields.exp == fp16_pkg::EXP_MAX) && (b_q.fields.mant == '0);

    assign hit_next = nan_a || nan_b || inf_a || inf_b;

    // priority: any nan, then inf minus inf, then whichever is infinite
    always_comb begin
        if (nan_a || nan_b) begin
            res_next.raw = fp16_pkg::QNAN;
        end else if (inf_a && inf_b && (a_q.fields.sign != b_q.fields.sign)) begin
            res_next.raw = fp16_pkg::QNAN;
        end else if (inf_a) begin
            res_next.raw = a_q.raw;
        end else if (inf_b) begin
            res_next.raw = b_q.raw;
        end else begin
            res_next.raw = '0;
        end
    end

    // --------------------
    // delay to meet the normalize register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SPECIAL_DELAY; i++) begin
                hit_pipe[i] <= 1'b0;
                res_pipe[i] <= '0;
            end
        end else begin
            hit_pipe[0] <= hit_next;
            res_pipe[0] <= res_next;
            for (int i = 1; i < SPECIAL_DELAY; i++) begin
                hit_pipe[i] <= hit_pipe[i-1];
                res_pipe[i] <= res_pipe[i-1];
            end
        end
    end

    assign special_hit = hit_pipe[SPECIAL_DELAY-1];
    assign special_result = res_pipe[SPECIAL_DELAY-1];

    // hit and value must stay paired through every delay stage
    hit_is_special: assert property (@(posedge clk) disable iff (!rst_n)
        special_hit |-> (special_result.fields.exp == fp16_pkg::EXP_MAX));

endmodule

`default_nettype wire

// File: logic/fp_add_stage.sv
`default_nettype none

module fp_add_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         sign_a,
    input  logic                         sign_b,
    input  logic [fp16_pkg::EXP_W-1:0]   exp_a,
    input  logic [fp16_pkg::EXP_W-1:0]   exp_b,
    input  logic                         same_sign,
    input  logic                         a_exp_ge,
    input  logic                         a_mag_gt,
    input  logic [fp16_pkg::ALIGN_W-1:0] m_a,
    input  logic [fp16_pkg::ALIGN_W-1:0] m_b,
    output logic                         sign_sum,
    output logic [fp16_pkg::EXP_W-1:0]   exp_sum,
    output logic [fp16_pkg::SUM_W-1:0]   mant_sum
);

    logic [fp16_pkg::SUM_W-1:0] ext_a;
    logic [fp16_pkg::SUM_W-1:0] ext_b;

    // one extra bit on top catches the carry
    assign ext_a = {1'b0, m_a};
    assign ext_b = {1'b0, m_b};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sign_sum <= 1'b0;
            exp_sum <= '0;
            mant_sum <= '0;
        end else begin
            // unlike signs take the sign of the larger magnitude
            sign_sum <= (same_sign || a_mag_gt) ? sign_a : sign_b;
            exp_sum <= a_exp_ge ? exp_a : exp_b;
            // effective subtract is always larger minus smaller
            if (same_sign) begin
                mant_sum <= ext_a + ext_b;
            end else if (a_mag_gt) begin
                mant_sum <= ext_a - ext_b;
            end else begin
                mant_sum <= ext_b - ext_a;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fp_norm_stage.sv
`default_nettype none

module fp_norm_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sign_sum,
    input  logic [fp16_pkg::EXP_W-1:0]  exp_sum,
    input  logic [fp16_pkg::SUM_W-1:0]  mant_sum,
    output logic                        sign_norm,
    output logic [fp16_pkg::EXP_W-1:0]  exp_norm,
    output logic [fp16_pkg::NORM_W-1:0] mant_norm
);

    localparam int SUM_W = fp16_pkg::SUM_W;
    localparam int NORM_W = fp16_pkg::NORM_W;
    localparam int EXP_W = fp16_pkg::EXP_W;

    logic [NORM_W-1:0] mant_next;
    logic [EXP_W-1:0]  exp_next;

    // --------------------
    // leading one and exponent adjust
    // --------------------
    always_comb begin
        int               lead;
        int               exp_tmp;
        logic             found;
        logic [SUM_W-1:0] shifted;

        // scan from the carry bit down for the first one
        lead = 0;
        found = 1'b0;
        for (int i = SUM_W - 1; i >= 0; i--) begin
            if (!found && mant_sum[i]) begin
                lead = i;
                found = 1'b1;
            end
        end

        // move the leading one up to the carry position
        // the bits right below it form the normalized field
        shifted = mant_sum << (SUM_W - 1 - lead);

        // bit 16 adds one, bit 15 keeps, bit p takes off 15 - p
        exp_tmp = int'(exp_sum) + lead - (SUM_W - 2);

        if (!found) begin
            mant_next = '0;
            exp_next = '0;
        end else begin
            mant_next = shifted[SUM_W-2 -: NORM_W];
            // underflow and overflow clamp, mantissa is kept as is
            if (exp_tmp < 0) begin
                exp_next = '0;
            end else if (exp_tmp > int'(fp16_pkg::EXP_MAX)) begin
                exp_next = fp16_pkg::EXP_MAX;
            end else begin
                exp_next = exp_tmp[EXP_W-1:0];
            end
        end
    end

    // --------------------
    // normalize register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sign_norm <= 1'b0;
            exp_norm <= '0;
            mant_norm <= '0;
        end else begin
            sign_norm <= sign_sum;
            exp_norm <= exp_next;
            mant_norm <= mant_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/fp_round_stage.sv
`default_nettype none

module fp_round_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sign_norm,
    input  logic [fp16_pkg::EXP_W-1:0]  exp_norm,
    input  logic [fp16_pkg::NORM_W-1:0] mant_norm,
    input  logic                        special_hit,
    input  fp16_pkg::fp16_t             special_result,
    output fp16_pkg::fp16_t             result
);

    localparam int MANT_W = fp16_pkg::MANT_W;
    localparam int EXP_W = fp16_pkg::EXP_W;
    localparam int NORM_W = fp16_pkg::NORM_W;
    // bit positions of guard and round inside mant_norm
    localparam int GUARD = NORM_W - MANT_W - 1;
    localparam int RND = GUARD - 1;

    logic [MANT_W-1:0] mant_main;
    logic              lsb;
    logic              guard_bit;
    logic              round_bit;
    logic              sticky_bit;
    logic              round_up;
    logic [MANT_W:0]   mant_round;
    logic [EXP_W:0]    exp_carry;
    logic [EXP_W-1:0]  exp_final;
    logic [MANT_W-1:0] mant_final;
    logic              sign_final;
    fp16_pkg::fp16_t   normal;

    // --------------------
    // round to nearest even
    // --------------------
    assign mant_main = mant_norm[NORM_W-1 -: MANT_W];
    assign lsb = mant_norm[GUARD+1];
    assign guard_bit = mant_norm[GUARD];
    assign round_bit = mant_norm[RND];
    assign sticky_bit = |mant_norm[RND-1:0];

    // above half, or exactly half with an odd lsb
    assign round_up = (guard_bit && round_bit)
                   || (guard_bit && !round_bit && sticky_bit)
                   || (lsb && guard_bit && !round_bit && !sticky_bit);

    assign mant_round = {1'b0, mant_main} + {{MANT_W{1'b0}}, round_up};

    // carry out of the mantissa bumps the exponent
    assign exp_carry = {1'b0, exp_norm} + {{EXP_W{1'b0}}, mant_round[MANT_W]};
    assign exp_final = (exp_carry > {1'b0, fp16_pkg::EXP_MAX}) ? fp16_pkg::EXP_MAX
                                                                 : exp_carry[EXP_W-1:0];
    assign mant_final = mant_round[MANT_W-1:0];

    // exact cancellation always gives +0
    assign sign_final = ((exp_final == '0) && (mant_final == '0)) ? 1'b0 : sign_norm;

    assign normal.raw = {sign_final, exp_final, mant_final};

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            // nan and inf override the arithmetic result
            result <= special_hit ? special_result : normal;
        end
    end

    // every register feeding result is reset, so no x may reach the output
    result_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(result));

endmodule

`default_nettype wire

// File: logic/fp16_add_top.sv
`default_nettype none

module fp16_add_top (
    input  logic            clk,
    input  logic            rst_n,
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    output fp16_pkg::fp16_t result
);

    // align stage outputs
    fp16_pkg::fp16_t              a_q;
    fp16_pkg::fp16_t              b_q;
    logic                         sign_a;
    logic                         sign_b;
    logic [fp16_pkg::EXP_W-1:0]   exp_a;
    logic [fp16_pkg::EXP_W-1:0]   exp_b;
    logic                         same_sign;
    logic                         a_exp_ge;
    logic                         a_mag_gt;
    logic [fp16_pkg::ALIGN_W-1:0] m_a;
    logic [fp16_pkg::ALIGN_W-1:0] m_b;

    // sum register
    logic                         sign_sum;
    logic [fp16_pkg::EXP_W-1:0]   exp_sum;
    logic [fp16_pkg::SUM_W-1:0]   mant_sum;

    // normalize register
    logic                         sign_norm;
    logic [fp16_pkg::EXP_W-1:0]   exp_norm;
    logic [fp16_pkg::NORM_W-1:0]  mant_norm;

    // special path, lined up with the normalize register
    logic                         special_hit;
    fp16_pkg::fp16_t              special_result;

    fp_align_stage fp_align_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .a         (a),
        .b         (b),
        .a_q       (a_q),
        .b_q       (b_q),
        .sign_a    (sign_a),
        .sign_b    (sign_b),
        .exp_a     (exp_a),
        .exp_b     (exp_b),
        .same_sign (same_sign),
        .a_exp_ge  (a_exp_ge),
        .a_mag_gt  (a_mag_gt),
        .m_a       (m_a),
        .m_b       (m_b)
    );

    // three registers cover the sum, normalize and align-to-sum gap
    fp_special_path #(
        .SPECIAL_DELAY (3)
    ) fp_special_path_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .a_q            (a_q),
        .b_q            (b_q),
        .special_hit    (special_hit),
        .special_result (special_result)
    );

    fp_add_stage fp_add_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sign_a    (sign_a),
        .sign_b    (sign_b),
        .exp_a     (exp_a),
        .exp_b     (exp_b),
        .same_sign (same_sign),
        .a_exp_ge  (a_exp_ge),
        .a_mag_gt  (a_mag_gt),
        .m_a       (m_a),
        .m_b       (m_b),
        .sign_sum  (sign_sum),
        .exp_sum   (exp_sum),
        .mant_sum  (mant_sum)
    );

    fp_norm_stage fp_norm_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sign_sum  (sign_sum),
        .exp_sum   (exp_sum),
        .mant_sum  (mant_sum),
        .sign_norm (sign_norm),
        .exp_norm  (exp_norm),
        .mant_norm (mant_norm)
    );

    fp_round_stage fp_round_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .sign_norm      (sign_norm),
        .exp_norm       (exp_norm),
        .mant_norm      (mant_norm),
        .special_hit    (special_hit),
        .special_result (special_result),
        .result         (result)
    );

endmodule

`default_nettype wire

// File: bench/fp16_ref.svh
`ifndef FP16_REF_SVH
`define FP16_REF_SVH

`default_nettype none

// --------------------
// operand classes
// --------------------

function automatic logic is_nan_operand(input fp16_pkg::fp16_t x);
    return (x.fields.exp == fp16_pkg::EXP_MAX) && (x.fields.mant != '0);
endfunction

function automatic logic is_inf_operand(input fp16_pkg::fp16_t x);
    return (x.fields.exp == fp16_pkg::EXP_MAX) && (x.fields.mant == '0);
endfunction

// 11-bit significand scaled by 32 so it sits in the 16-bit alignment frame
// subnormals get no hidden bit
function automatic int aligned_significand(input fp16_pkg::fp16_t x);
    int hidden;
    hidden = (x.fields.exp != '0) ? 1 : 0;
    return (hidden * 1024 + int'(x.fields.mant)) * 32;
endfunction

// position of the highest set bit in a 17-bit sum, -1 for zero
function automatic int leading_one_pos(input int v);
    int pos;
    pos = -1;
    for (int i = 0; i < 17; i++) begin
        if (((v >> i) & 1) == 1) begin
            pos = i;
        end
    end
    return pos;
endfunction

// --------------------
// expected sum
// --------------------

function automatic fp16_pkg::fp16_t fp16_ref_add(input fp16_pkg::fp16_t a,
                                                 input fp16_pkg::fp16_t b);
    fp16_pkg::fp16_t res;
    int              ea;
    int              eb;
    int              fa;
    int              fb;
    int              gap;
    int              big_exp;
    int              total;
    int              top;
    int              e;
    int              norm;
    int              mant;
    int              lsb;
    int              guard;
    int              rnd;
    int              sticky;
    logic            sgn;

    // nan wins, then inf - inf, then the infinite operand itself
    if (is_nan_operand(a) || is_nan_operand(b)) begin
        return fp16_pkg::QNAN;
    end
    if (is_inf_operand(a) && is_inf_operand(b) && (a.fields.sign != b.fields.sign)) begin
        return fp16_pkg::QNAN;
    end
    if (is_inf_operand(a)) begin
        return a;
    end
    if (is_inf_operand(b)) begin
        return b;
    end

    ea = int'(a.fields.exp);
    eb = int'(b.fields.exp);
    fa = aligned_significand(a);
    fb = aligned_significand(b);

    // smaller exponent side moves right, by at most 15 places
    gap = (ea > eb) ? (ea - eb) : (eb - ea);
    if (gap > 15) begin
        gap = 15;
    end
    if (ea > eb) begin
        fb = fb >> gap;
    end else if (eb > ea) begin
        fa = fa >> gap;
    end
    big_exp = (ea >= eb) ? ea : eb;

    // signed magnitude add, ties in magnitude take the sign of b
    if (a.fields.sign == b.fields.sign) begin
        total = fa + fb;
        sgn = a.fields.sign;
    end else if (fa > fb) begin
        total = fa - fb;
        sgn = a.fields.sign;
    end else begin
        total = fb - fa;
        sgn = b.fields.sign;
    end

    top = leading_one_pos(total);
    if (top < 0) begin
        e = 0;
        norm = 0;
    end else begin
        // bit 15 is the reference point for the exponent
        e = big_exp + top - 15;
        // drop the leading one and left justify the rest in 15 bits
        norm = ((total << (16 - top)) >> 1) & 32'h7FFF;
        if (e < 0) begin
            e = 0;
        end else if (e > 31) begin
            e = 31;
        end
    end

    // nearest even on guard, round and sticky
    mant = norm >> 5;
    lsb = mant & 1;
    guard = (norm >> 4) & 1;
    rnd = (norm >> 3) & 1;
    sticky = norm & 7;
    if (guard == 1 && (rnd == 1 || sticky != 0 || lsb == 1)) begin
        mant = mant + 1;
    end
    if (mant == 1024) begin
        mant = 0;
        e = (e >= 31) ? 31 : e + 1;
    end

    if (e == 0 && mant == 0) begin
        sgn = 1'b0;
    end

    res.fields.sign = sgn;
    res.fields.exp = e[4:0];
    res.fields.mant = mant[9:0];
    return res;
endfunction

`default_nettype wire

`endif

// File: bench/fp16_add_tb.sv
`include "fp16_ref.svh"

`default_nettype none

module fp16_add_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES = 4;
    localparam int DIRECTED_MAX = 48;
    localparam int RANDOM_PAIRS = 400;
    // one pair per cycle plus reset, idle and room for the pipeline to drain
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + DIRECTED_MAX
                                  + RANDOM_PAIRS + 32;
    // counter still shows the previous edge at drive time
    // operands load one edge later and the result follows four edges after that
    localparam int RESULT_OFFSET = 6;

    logic            clk = 1'b0;
    logic            rst_n;
    fp16_pkg::fp16_t a;
    fp16_pkg::fp16_t b;
    fp16_pkg::fp16_t result;

    int     cycle = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    logic   started = 1'b0;
    integer seed;

    // expected results in drive order
    fp16_pkg::fp16_t want_q [$];
    string           name_q [$];
    int              due_q [$];

    fp16_add_top fp16_add_top_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .a      (a),
        .b      (b),
        .result (result)
    );

    always #2 clk = ~clk;

    // --------------------
    // helpers
    // --------------------

    task automatic check_result(input string test_name, input fp16_pkg::fp16_t expected,
                                input fp16_pkg::fp16_t actual);
        if (actual.raw !== expected.raw) begin
            value_errors++;
            $display("[FAIL] %s expected %04h actual %04h at %0t",
                     test_name, expected.raw, actual.raw, $time);
        end
    endtask

    // one pair per rising edge with its expected value queued alongside
    task automatic drive_pair(input fp16_pkg::fp16_t x, input fp16_pkg::fp16_t y,
                              input string test_name);
        @(posedge clk);
        a <= x;
        b <= y;
        started = 1'b1;
        want_q.push_back(fp16_ref_add(x, y));
        name_q.push_back(test_name);
        due_q.push_back(cycle + RESULT_OFFSET);
    endtask

    task automatic print_counts();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
    endtask

    // --------------------
    // cycle count and timeout
    // --------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles, %0d results pending",
                     TIMEOUT_CYCLES, due_q.size());
            other_errors++;
            print_counts();
            $display("TB FAILED");
            $finish;
        end
    end

    // --------------------
    // compare on the falling edge where result is stable
    // --------------------
    always @(negedge clk) begin : compare_results
        fp16_pkg::fp16_t want;
        string           test_name;
        int              due;
        if (!started) begin
            // reset and the idle cycles before any operands
            check_result("reset_and_idle", '0, result);
        end else if (due_q.size() > 0) begin
            if (due_q[0] <= cycle) begin
                want = want_q.pop_front();
                test_name = name_q.pop_front();
                due = due_q.pop_front();
                if (due == cycle) begin
                    check_result(test_name, want, result);
                end else begin
                    other_errors++;
                    $display("result for %s was skipped by the compare process", test_name);
                end
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin : stimulus
        fp16_pkg::fp16_t ra;
        fp16_pkg::fp16_t rb;
        logic [31:0]     r;
        seed = 32'h1e99_2c76;
        rst_n = 1'b0;
        // nonzero operands during reset must not reach the pipeline
        a = 16'h3C00;
        b = 16'h3C00;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        a <= '0;
        b <= '0;
        repeat (IDLE_CYCLES) @(posedge clk);

        // same sign, equal and differing exponents
        drive_pair(16'h3C00, 16'h3C00, "same_exp_carry");
        drive_pair(16'h3E00, 16'h3E00, "same_exp_carry_frac");
        drive_pair(16'h4000, 16'h3C00, "diff_exp_add");
        drive_pair(16'h3C00, 16'h3800, "diff_exp_add_small_b");
        drive_pair(16'h3555, 16'h4A3D, "diff_exp_mixed");
        drive_pair(16'hC000, 16'hBC00, "neg_same_sign");
        drive_pair(16'h0001, 16'h0003, "subnormal_add");
        drive_pair(16'h0400, 16'h0001, "normal_plus_subnormal");
        // opposite sign, cancellation and the shift clamp
        drive_pair(16'h3C00, 16'hBC00, "exact_cancel");
        drive_pair(16'hBC00, 16'h3C00, "exact_cancel_neg_first");
        drive_pair(16'h4200, 16'hC000, "opp_sign_a_larger");
        drive_pair(16'h3C00, 16'hC200, "opp_sign_b_larger");
        drive_pair(16'h3C01, 16'hBC00, "opp_sign_one_ulp");
        drive_pair(16'h7800, 16'h3800, "gap_16_clamped");
        drive_pair(16'h3800, 16'hF800, "gap_16_clamped_neg");
        drive_pair(16'h7BFF, 16'h0400, "gap_29_clamped");
        drive_pair(16'h7800, 16'hBC00, "gap_15_sub");
        // rounding corners
        drive_pair(16'h3C00, 16'h1000, "tie_even_down");
        drive_pair(16'h3C01, 16'h1000, "tie_even_up");
        drive_pair(16'h3C00, 16'h0C00, "round_bit_only");
        drive_pair(16'h3C00, 16'h0800, "sticky_only");
        drive_pair(16'h3C00, 16'h1100, "guard_sticky_up");
        drive_pair(16'h3C00, 16'h1200, "guard_round_up");
        drive_pair(16'h3FFF, 16'h1000, "round_carry_exp");
        drive_pair(16'h7BFF, 16'h7BFF, "exp_clamp_overflow");
        drive_pair(16'h3C00, 16'h9000, "sub_tie");
        // nan and infinity
        drive_pair(16'h7E00, 16'h3C00, "nan_a");
        drive_pair(16'h3C00, 16'h7C01, "nan_b");
        drive_pair(16'hFD00, 16'h7C00, "nan_with_inf");
        drive_pair(16'h7C00, 16'h3C00, "inf_plus_finite");
        drive_pair(16'h4000, 16'hFC00, "finite_plus_neg_inf");
        drive_pair(16'h7C00, 16'h7C00, "inf_plus_inf");
        drive_pair(16'hFC00, 16'hFC00, "neg_inf_plus_neg_inf");
        drive_pair(16'h7C00, 16'hFC00, "inf_minus_inf");
        drive_pair(16'hFC00, 16'h7C00, "neg_inf_plus_inf");
        // signed zeros
        drive_pair(16'h8000, 16'h8000, "neg_zero_sum");
        drive_pair(16'h0000, 16'h8000, "mixed_zero");

        // back to back random pairs
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            r = $random(seed);
            ra.raw = r[15:0];
            rb.raw = r[31:16];
            // shared exponent every fourth pair so cancellation shows up often
            if (i % 4 == 3) begin
                rb.fields.exp = ra.fields.exp;
            end
            drive_pair(ra, rb, $sformatf("random_%0d", i));
        end

        @(posedge clk);
        a <= '0;
        b <= '0;
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+bench
logic/fp16_pkg.sv
logic/fp_align_stage.sv
logic/fp_special_path.sv
logic/fp_add_stage.sv
logic/fp_norm_stage.sv
logic/fp_round_stage.sv
logic/fp16_add_top.sv
bench/fp16_add_tb.sv

// File: Makefile
# Verilator build for the fp16 adder testbench

VERILATOR ?= verilator
TOP       := fp16_add_tb
RTL_TOP   := fp16_add_top
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := run.log
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/fp16_ref.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
